// ==== rtl/sorter_pkg.sv ====
/*
 * shared types and register map of the APB sort accelerator
 * data vectors are sized per module, so only APB structs live here
 * data slots are word aligned, 0x20 to 0x3C, one lane each
 */
package sorter_pkg;

    // sorter geometry
    localparam int LANES       = 8;
    localparam int COUNT_WIDTH = 4;

    // byte addresses
    localparam logic [7:0] ADDR_CTRL      = 8'h00;
    localparam logic [7:0] ADDR_DATA_BASE = 8'h20;

    // control word on write
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_COUNT_LSB = 1;
    localparam int CTRL_COUNT_MSB = 4;

    // status word on read
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_READY_BIT = 1;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // decoded target of one access
    typedef enum logic [1:0] {SEL_CTRL, SEL_DATA, SEL_NONE} reg_sel_e;

    typedef enum logic [1:0] {ST_IDLE, ST_SORTING, ST_READY} sort_state_e;

endpackage

// ==== rtl/sort_comparator.sv ====
/*
 * registered compare-exchange, one cycle of latency
 * unsigned compare only, smaller value leaves on low_out
 */
`timescale 1ns/1ps

module sort_comparator #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clock,
    input  logic [DATA_WIDTH-1:0] a_in,
    input  logic [DATA_WIDTH-1:0] b_in,
    output logic [DATA_WIDTH-1:0] low_out,
    output logic [DATA_WIDTH-1:0] high_out
);

    // data path only, no reset
    always_ff @(posedge clock) begin
        if (a_in <= b_in) begin
            low_out  <= a_in;
            high_out <= b_in;
        end else begin
            // swap
            low_out  <= b_in;
            high_out <= a_in;
        end
    end

endmodule

// ==== rtl/batcher_sorter_4.sv ====
/*
 * four-input odd-even merge sorter, three registered stages
 * lane 0 of data_out holds the smallest value
 */
`timescale 1ns/1ps

module batcher_sorter_4 #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clock,
    input  logic [4*DATA_WIDTH-1:0] data_in,
    output logic [4*DATA_WIDTH-1:0] data_out
);

    logic [DATA_WIDTH-1:0] a0, a1, a2, a3;
    logic [DATA_WIDTH-1:0] b0, b1, b2, b3;
    logic [DATA_WIDTH-1:0] c1, c2;
    logic [DATA_WIDTH-1:0] d0, d3;

    // stage 1: sort the two pairs
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_s1_lo (
        .clock(clock), .a_in(data_in[0*DATA_WIDTH +: DATA_WIDTH]),
        .b_in(data_in[1*DATA_WIDTH +: DATA_WIDTH]), .low_out(a0), .high_out(a1)
    );
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_s1_hi (
        .clock(clock), .a_in(data_in[2*DATA_WIDTH +: DATA_WIDTH]),
        .b_in(data_in[3*DATA_WIDTH +: DATA_WIDTH]), .low_out(a2), .high_out(a3)
    );

    // stage 2: cross, mins to lane 0 and maxes to lane 3
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_s2_even (
        .clock(clock), .a_in(a0), .b_in(a2), .low_out(b0), .high_out(b2)
    );
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_s2_odd (
        .clock(clock), .a_in(a1), .b_in(a3), .low_out(b1), .high_out(b3)
    );

    // stage 3: only the middle pair can still be out of order
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_s3_mid (
        .clock(clock), .a_in(b1), .b_in(b2), .low_out(c1), .high_out(c2)
    );

    // outer lanes delayed to stay aligned
    always_ff @(posedge clock) begin
        d0 <= b0;
        d3 <= b3;
    end

    assign data_out = {d3, c2, c1, d0};

endmodule

// ==== rtl/batcher_sorter_8.sv ====
/*
 * eight-input Batcher odd-even merge sorter, 6 cycles of latency
 * two 4-sorters then three merge stages; no back-pressure
 * count rides beside the data, only the valid line is reset
 */
`timescale 1ns/1ps

module batcher_sorter_8 #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [sorter_pkg::LANES*DATA_WIDTH-1:0] data_in,
    input  logic [sorter_pkg::COUNT_WIDTH-1:0]     count_in,
    input  logic                                   valid_in,
    output logic [sorter_pkg::LANES*DATA_WIDTH-1:0] data_out,
    output logic [sorter_pkg::COUNT_WIDTH-1:0]     count_out,
    output logic                                   valid_out
);

    localparam int LATENCY = 6;
    localparam int HALF    = 4*DATA_WIDTH;

    logic [HALF-1:0]       lo_sorted, hi_sorted;
    logic [DATA_WIDTH-1:0] ma [8];
    logic [DATA_WIDTH-1:0] b0, b1, b2, b3, b4, b5, b6, b7;
    logic [DATA_WIDTH-1:0] c0, c1, c2, c3, c4, c5, c6, c7;

    logic [LATENCY-1:0]                valid_pipe;
    logic [sorter_pkg::COUNT_WIDTH-1:0] count_pipe [LATENCY];

    ////////////////////////////////////////////////////////////////////////////
    // stages 1 to 3, each half sorted on its own
    ////////////////////////////////////////////////////////////////////////////

    batcher_sorter_4 #(.DATA_WIDTH(DATA_WIDTH)) sort_lo (
        .clock(clock), .data_in(data_in[0 +: HALF]), .data_out(lo_sorted)
    );
    batcher_sorter_4 #(.DATA_WIDTH(DATA_WIDTH)) sort_hi (
        .clock(clock), .data_in(data_in[HALF +: HALF]), .data_out(hi_sorted)
    );

    ////////////////////////////////////////////////////////////////////////////
    // merge, stages 4 to 6
    ////////////////////////////////////////////////////////////////////////////

    // lane i against lane i+4
    for (genvar i = 0; i < 4; i++) begin : g_merge_a
        sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_a (
            .clock(clock),
            .a_in(lo_sorted[i*DATA_WIDTH +: DATA_WIDTH]),
            .b_in(hi_sorted[i*DATA_WIDTH +: DATA_WIDTH]),
            .low_out(ma[i]),
            .high_out(ma[i+4])
        );
    end

    // 2-4 and 3-5; outer lanes already final for this stage
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_b_24 (
        .clock(clock), .a_in(ma[2]), .b_in(ma[4]), .low_out(b2), .high_out(b4)
    );
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_b_35 (
        .clock(clock), .a_in(ma[3]), .b_in(ma[5]), .low_out(b3), .high_out(b5)
    );

    // neighbour pairs, lanes 0 and 7 pass
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_c_12 (
        .clock(clock), .a_in(b1), .b_in(b2), .low_out(c1), .high_out(c2)
    );
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_c_34 (
        .clock(clock), .a_in(b3), .b_in(b4), .low_out(c3), .high_out(c4)
    );
    sort_comparator #(.DATA_WIDTH(DATA_WIDTH)) cmp_c_56 (
        .clock(clock), .a_in(b5), .b_in(b6), .low_out(c5), .high_out(c6)
    );

    // pass-through registers of the merge stages
    always_ff @(posedge clock) begin
        b0 <= ma[0];
        b1 <= ma[1];
        b6 <= ma[6];
        b7 <= ma[7];
        c0 <= b0;
        c7 <= b7;
    end

    assign data_out = {c7, c6, c5, c4, c3, c2, c1, c0};

    // valid and count delay lines, matched to the data latency
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[LATENCY-2:0], valid_in};
        end
    end

    always_ff @(posedge clock) begin
        count_pipe[0] <= count_in;
        for (int i = 1; i < LATENCY; i++) begin
            count_pipe[i] <= count_pipe[i-1];
        end
    end

    assign valid_out = valid_pipe[LATENCY-1];
    assign count_out = count_pipe[LATENCY-1];

endmodule

// ==== rtl/batch_loader.sv ====
/*
 * staging slots and batch launch
 * lanes at or above start_count go out as all-ones and sort to the top
 * start_count is assumed to be 1 to 8, already checked upstream
 */
`timescale 1ns/1ps

module batch_loader #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    slot_write,
    input  logic [$clog2(sorter_pkg::LANES)-1:0]    slot_index,
    input  logic [DATA_WIDTH-1:0]                   slot_data,
    input  logic                                    start,
    input  logic [sorter_pkg::COUNT_WIDTH-1:0]      start_count,
    output logic                                    batch_valid,
    output logic [sorter_pkg::LANES*DATA_WIDTH-1:0] batch_data,
    output logic [sorter_pkg::COUNT_WIDTH-1:0]      batch_count
);

    logic [DATA_WIDTH-1:0] slots [sorter_pkg::LANES];

    // staging slots and launch strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < sorter_pkg::LANES; i++) begin
                slots[i] <= '0;
            end
            batch_valid <= 1'b0;
        end else begin
            if (slot_write) begin
                slots[slot_index] <= slot_data;
            end
            // one cycle, the cycle after the start access
            batch_valid <= start;
        end
    end

    // launch copy, staging stays intact for the next batch
    always_ff @(posedge clock) begin
        if (start) begin
            for (int i = 0; i < sorter_pkg::LANES; i++) begin
                batch_data[i*DATA_WIDTH +: DATA_WIDTH] <= (i < start_count) ? slots[i] : '1;
            end
            batch_count <= start_count;
        end
    end

endmodule

// ==== rtl/result_buffer.sv ====
/*
 * result capture and sort state
 * one batch in flight at a time; a new launch from READY keeps the old
 * result visible until the new batch arrives
 */
`timescale 1ns/1ps

module result_buffer #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    launch,
    input  logic                                    sorted_valid,
    input  logic [sorter_pkg::LANES*DATA_WIDTH-1:0] sorted_data,
    input  logic [sorter_pkg::COUNT_WIDTH-1:0]      sorted_count,
    output sorter_pkg::sort_state_e                 state,
    output logic [sorter_pkg::LANES*DATA_WIDTH-1:0] result_data,
    output logic [sorter_pkg::COUNT_WIDTH-1:0]      result_count
);

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= sorter_pkg::ST_IDLE;
            result_data  <= '0;
            result_count <= '0;
        end else begin
            case (state)
                sorter_pkg::ST_IDLE, sorter_pkg::ST_READY: begin
                    if (launch) state <= sorter_pkg::ST_SORTING;
                end
                sorter_pkg::ST_SORTING: begin
                    if (sorted_valid) state <= sorter_pkg::ST_READY;
                end
                default: state <= sorter_pkg::ST_IDLE;
            endcase
            // capture sorted batch with its count
            if (sorted_valid) begin
                result_data  <= sorted_data;
                result_count <= sorted_count;
            end
        end
    end

endmodule

// ==== rtl/apb_sort_regs.sv ====
/*
 * APB slave of the sort accelerator, no wait states
 * refused: start while busy, start with count 0 or above 8, unmapped address
 * read data is combinational; slots at or past the count read as zero
 */
`timescale 1ns/1ps

module apb_sort_regs #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  sorter_pkg::apb_req_t                    apb_req,
    output sorter_pkg::apb_rsp_t                    apb_rsp,
    output logic                                    slot_write,
    output logic [$clog2(sorter_pkg::LANES)-1:0]    slot_index,
    output logic [DATA_WIDTH-1:0]                   slot_data,
    output logic                                    start,
    output logic [sorter_pkg::COUNT_WIDTH-1:0]      start_count,
    input  sorter_pkg::sort_state_e                 state,
    input  logic [sorter_pkg::LANES*DATA_WIDTH-1:0] result_data,
    input  logic [sorter_pkg::COUNT_WIDTH-1:0]      result_count
);

    logic                                   access;
    sorter_pkg::reg_sel_e                   sel;
    logic                                   wr_start;
    logic [sorter_pkg::COUNT_WIDTH-1:0]     wr_count;
    logic                                   launch_pending;
    logic                                   busy;
    logic                                   refuse;
    logic [DATA_WIDTH-1:0]                  read_lane;

    assign access = apb_req.psel & apb_req.penable;

    // address decode, data window is 0x20 to 0x3C word aligned
    always_comb begin
        sel = sorter_pkg::SEL_NONE;
        if (apb_req.paddr == sorter_pkg::ADDR_CTRL) begin
            sel = sorter_pkg::SEL_CTRL;
        end else if (apb_req.paddr[7:5] == sorter_pkg::ADDR_DATA_BASE[7:5] &&
                     apb_req.paddr[1:0] == 2'b00) begin
            sel = sorter_pkg::SEL_DATA;
        end
    end

    assign wr_start = apb_req.pwdata[sorter_pkg::CTRL_START_BIT];
    assign wr_count = apb_req.pwdata[sorter_pkg::CTRL_COUNT_MSB:sorter_pkg::CTRL_COUNT_LSB];

    // covers the cycle between an accepted start and the state change
    always_ff @(posedge clock) begin
        if (reset) begin
            launch_pending <= 1'b0;
        end else begin
            launch_pending <= start;
        end
    end

    assign busy = (state == sorter_pkg::ST_SORTING) | launch_pending;

    // refusal rules
    assign refuse = (sel == sorter_pkg::SEL_NONE) ||
                    (sel == sorter_pkg::SEL_CTRL && apb_req.pwrite && wr_start &&
                     (busy || wr_count == '0 || wr_count > sorter_pkg::LANES));

    // strobes, only in an accepted access cycle
    assign slot_write  = access & apb_req.pwrite & (sel == sorter_pkg::SEL_DATA);
    assign slot_index  = apb_req.paddr[4:2];
    assign slot_data   = apb_req.pwdata[DATA_WIDTH-1:0];
    assign start       = access & apb_req.pwrite & (sel == sorter_pkg::SEL_CTRL) &
                         wr_start & ~refuse;
    assign start_count = wr_count;

    assign read_lane = result_data[slot_index*DATA_WIDTH +: DATA_WIDTH];

    // read mux
    always_comb begin
        apb_rsp.prdata = '0;
        case (sel)
            sorter_pkg::SEL_CTRL: begin
                apb_rsp.prdata[sorter_pkg::STAT_BUSY_BIT]  = busy;
                apb_rsp.prdata[sorter_pkg::STAT_READY_BIT] = (state == sorter_pkg::ST_READY);
            end
            sorter_pkg::SEL_DATA: begin
                if (slot_index < result_count) apb_rsp.prdata = 32'(read_lane);
            end
            default: apb_rsp.prdata = '0;
        endcase
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & refuse;
    end

endmodule

// ==== rtl/sorter_apb_top.sv ====
/*
 * top level of the APB sort accelerator, wiring only
 * READY shows in the status 8 cycles after an accepted start
 */
`timescale 1ns/1ps

module sorter_apb_top #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                 clock,
    input  logic                 reset,
    input  sorter_pkg::apb_req_t apb_req,
    output sorter_pkg::apb_rsp_t apb_rsp
);

    // register block to loader
    logic                                    slot_write;
    logic [$clog2(sorter_pkg::LANES)-1:0]    slot_index;
    logic [DATA_WIDTH-1:0]                   slot_data;
    logic                                    start;
    logic [sorter_pkg::COUNT_WIDTH-1:0]      start_count;

    // loader to sorter, batch_valid doubles as launch mark
    logic                                    batch_valid;
    logic [sorter_pkg::LANES*DATA_WIDTH-1:0] batch_data;
    logic [sorter_pkg::COUNT_WIDTH-1:0]      batch_count;

    // sorter to result buffer
    logic                                    sorted_valid;
    logic [sorter_pkg::LANES*DATA_WIDTH-1:0] sorted_data;
    logic [sorter_pkg::COUNT_WIDTH-1:0]      sorted_count;

    // result buffer back to register block
    sorter_pkg::sort_state_e                 state;
    logic [sorter_pkg::LANES*DATA_WIDTH-1:0] result_data;
    logic [sorter_pkg::COUNT_WIDTH-1:0]      result_count;

    apb_sort_regs #(.DATA_WIDTH(DATA_WIDTH)) regs_inst (
        .clock(clock), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .slot_write(slot_write), .slot_index(slot_index), .slot_data(slot_data),
        .start(start), .start_count(start_count),
        .state(state), .result_data(result_data), .result_count(result_count)
    );

    batch_loader #(.DATA_WIDTH(DATA_WIDTH)) loader_inst (
        .clock(clock), .reset(reset),
        .slot_write(slot_write), .slot_index(slot_index), .slot_data(slot_data),
        .start(start), .start_count(start_count),
        .batch_valid(batch_valid), .batch_data(batch_data), .batch_count(batch_count)
    );

    batcher_sorter_8 #(.DATA_WIDTH(DATA_WIDTH)) sorter_inst (
        .clock(clock), .reset(reset),
        .data_in(batch_data), .count_in(batch_count), .valid_in(batch_valid),
        .data_out(sorted_data), .count_out(sorted_count), .valid_out(sorted_valid)
    );

    result_buffer #(.DATA_WIDTH(DATA_WIDTH)) result_inst (
        .clock(clock), .reset(reset), .launch(batch_valid),
        .sorted_valid(sorted_valid), .sorted_data(sorted_data),
        .sorted_count(sorted_count), .state(state),
        .result_data(result_data), .result_count(result_count)
    );

endmodule

// ==== verif/sorter_properties.sv ====
/*
 * APB response and sort state rules, bound into apb_sort_regs
 * checked outside reset only
 */
`timescale 1ns/1ps

module sorter_properties (
    input logic                    clock,
    input logic                    reset,
    input sorter_pkg::apb_req_t    apb_req,
    input sorter_pkg::apb_rsp_t    apb_rsp,
    input sorter_pkg::sort_state_e state
);

    // no wait states, ever
    pready_high: assert property (@(posedge clock) disable iff (reset) apb_rsp.pready)
        else $error("pready dropped low");

    // error response belongs to the access phase
    pslverr_in_access: assert property (@(posedge clock) disable iff (reset)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr outside an access cycle");

    // a running sort only ends in READY
    sorting_not_idle: assert property (@(posedge clock) disable iff (reset)
        (state == sorter_pkg::ST_SORTING) |=> (state != sorter_pkg::ST_IDLE))
        else $error("state went from SORTING to IDLE");

endmodule

bind apb_sort_regs sorter_properties props_inst (
    .clock(clock), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp), .state(state)
);

// ==== verif/sorter_tb.sv ====
/*
 * directed testbench of the APB sort accelerator at DATA_WIDTH 32
 * one batch in flight at a time, the host polls READY between batches
 */
`timescale 1ns/1ps

module sorter_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                 clock;
    logic                 reset;
    sorter_pkg::apb_req_t apb_req;
    sorter_pkg::apb_rsp_t apb_rsp;
    logic [31:0]          lcg_state;
    logic [31:0]          values [8];
    logic [31:0]          expected [8];
    int                   cycle_count = 0;

    sorter_apb_top #(.DATA_WIDTH(32)) sorter_apb_top_inst (
        .clock(clock), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD/2) clock = ~clock;
    end

    // about 25 batches of ~45 cycles each, limit leaves wide margin
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] want,
                               input string what);
        if (actual !== want) begin
            $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, actual, want);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB host, entered and left 1 ns after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clock);
        #1;
        apb_req.penable = 1'b1;
        // response is combinational, stable well before the edge
        #1;
        err = apb_rsp.pslverr;
        @(posedge clock);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(posedge clock);
        #1;
        apb_req.penable = 1'b1;
        #1;
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        @(posedge clock);
        #1;
        apb_req = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // batch helpers and reference model
    ////////////////////////////////////////////////////////////////////////////

    // ascending insertion sort of the first count values, rest read as zero
    function automatic void reference_sort(input int count);
        logic [31:0] key;
        int          j;
        for (int i = 0; i < 8; i++) expected[i] = (i < count) ? values[i] : 32'd0;
        for (int i = 1; i < count; i++) begin
            key = expected[i];
            j   = i - 1;
            while (j >= 0 && expected[j] > key) begin
                expected[j+1] = expected[j];
                j--;
            end
            expected[j+1] = key;
        end
    endfunction

    task automatic write_slots();
        logic err;
        for (int i = 0; i < 8; i++) begin
            apb_write(sorter_pkg::ADDR_DATA_BASE + 8'(4*i), values[i], err);
            check_value({31'd0, err}, 32'd0, "pslverr on slot write");
        end
    endtask

    task automatic start_batch(input int count);
        logic err;
        apb_write(sorter_pkg::ADDR_CTRL, 32'((count << 1) | 1), err);
        check_value({31'd0, err}, 32'd0, "pslverr on accepted start");
    endtask

    task automatic check_results();
        logic [31:0] data;
        logic        err;
        for (int i = 0; i < 8; i++) begin
            apb_read(sorter_pkg::ADDR_DATA_BASE + 8'(4*i), data, err);
            check_value(data, expected[i], $sformatf("slot %0d", i));
        end
    endtask

    // poll until READY, then BUSY must be clear
    task automatic finish_batch(input int count);
        logic [31:0] status;
        logic        err;
        reference_sort(count);
        do begin
            apb_read(sorter_pkg::ADDR_CTRL, status, err);
        end while (!status[sorter_pkg::STAT_READY_BIT]);
        check_value(status & 32'h3, 32'h2, "status after sort");
        check_results();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_full_batch();
        for (int i = 0; i < 8; i++) values[i] = next_random();
        write_slots();
        start_batch(8);
        finish_batch(8);
    endtask

    // stale small values above the count must not leak into the result
    task automatic test_partial_batch();
        for (int i = 0; i < 5; i++) values[i] = next_random();
        values[5] = 32'd1;
        values[6] = 32'd2;
        values[7] = 32'd3;
        write_slots();
        start_batch(5);
        finish_batch(5);
    endtask

    task automatic test_extremes();
        values = '{32'd0, 32'hffff_ffff, 32'd7, 32'd7, 32'd0, 32'hffff_ffff, 32'd7, 32'd1};
        write_slots();
        start_batch(8);
        finish_batch(8);
    endtask

    task automatic test_refused_accesses();
        logic [31:0] data;
        logic        err;
        for (int i = 0; i < 8; i++) values[i] = next_random();
        write_slots();
        start_batch(8);
        // second start with count 3 lands while the first batch is in flight
        apb_write(sorter_pkg::ADDR_CTRL, 32'h07, err);
        check_value({31'd0, err}, 32'd1, "pslverr on start while busy");
        finish_batch(8);
        apb_write(sorter_pkg::ADDR_CTRL, 32'h01, err);
        check_value({31'd0, err}, 32'd1, "pslverr on count 0");
        apb_write(sorter_pkg::ADDR_CTRL, 32'h13, err);
        check_value({31'd0, err}, 32'd1, "pslverr on count 9");
        apb_write(8'h10, 32'hdead_beef, err);
        check_value({31'd0, err}, 32'd1, "pslverr on unmapped write");
        apb_read(8'h10, data, err);
        check_value({31'd0, err}, 32'd1, "pslverr on unmapped read");
        // nothing above may have moved the state or the result
        apb_read(sorter_pkg::ADDR_CTRL, data, err);
        check_value(data & 32'h3, 32'h2, "status after refused accesses");
        check_results();
        // relaunch the staged slots to see the unmapped write left them alone
        start_batch(8);
        finish_batch(8);
    endtask

    task automatic test_random_batches();
        int          count;
        logic [31:0] r;
        repeat (20) begin
            for (int i = 0; i < 8; i++) values[i] = next_random();
            r     = next_random();
            count = int'(r[31:29]) + 1;
            write_slots();
            start_batch(count);
            finish_batch(count);
        end
    endtask

    initial begin
        apb_req   = '0;
        reset     = 1'b1;
        lcg_state = 32'h85682345;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        test_full_batch();
        test_partial_batch();
        test_extremes();
        test_refused_accesses();
        test_random_batches();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/sorter_pkg.sv
rtl/sort_comparator.sv
rtl/batcher_sorter_4.sv
rtl/batcher_sorter_8.sv
rtl/batch_loader.sv
rtl/result_buffer.sv
rtl/apb_sort_regs.sv
rtl/sorter_apb_top.sv
verif/sorter_properties.sv
verif/sorter_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the sorter testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f src.f --top-module sorter_tb -Mdir obj_dir; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vsorter_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -qx "=== PASS ===" <<< "$output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
